//--- design/dcache_bank_ctrl.sv
////////////////////
// dcache bank control
// drives request, write enable, index, byte enables and write data
// of every data bank from the refill, the granted read and the
// single word write, and acknowledges the word write
////////////////////
`default_nettype none

module dcache_bank_ctrl (
  input  logic                  rd_acked_i,
  input  dcache_pkg::off_t      rd_off_i,
  input  dcache_pkg::idx_t      rd_idx_i,
  input  logic                  wr_cl_vld_i,
  input  dcache_pkg::way_mask_t wr_cl_we_i,
  input  dcache_pkg::idx_t      wr_cl_idx_i,
  input  dcache_pkg::line_t     wr_cl_data_i,
  input  dcache_pkg::line_be_t  wr_cl_data_be_i,
  input  dcache_pkg::way_mask_t wr_req_i,
  input  dcache_pkg::idx_t      wr_idx_i,
  input  dcache_pkg::off_t      wr_off_i,
  input  dcache_pkg::word_t     wr_data_i,
  input  dcache_pkg::word_be_t  wr_data_be_i,
  output logic                  wr_ack_o,
  output logic [dcache_pkg::NumBanks-1:0] bank_req_o,
  output logic [dcache_pkg::NumBanks-1:0] bank_we_o,
  output dcache_pkg::idx_t [dcache_pkg::NumBanks-1:0] bank_idx_o,
  output dcache_pkg::word_be_t [dcache_pkg::NumBanks-1:0][dcache_pkg::NumWays-1:0] bank_be_o,
  output dcache_pkg::word_t [dcache_pkg::NumBanks-1:0][dcache_pkg::NumWays-1:0] bank_wdata_o
);

  localparam int unsigned BeWidth = dcache_pkg::WordWidth / 8;

  dcache_pkg::bank_sel_t rd_bank;
  dcache_pkg::bank_sel_t wr_bank;
  logic                  collision;

  assign rd_bank = dcache_pkg::bank_of(rd_off_i);
  assign wr_bank = dcache_pkg::bank_of(wr_off_i);

  // a read and a word write can share a cycle only in different banks
  assign collision = rd_acked_i & (rd_bank == wr_bank);
  assign wr_ack_o  = (|wr_req_i) & ~wr_cl_vld_i & ~collision;

  always_comb begin : p_bank_req
    bank_req_o = '0;
    bank_we_o  = '0;
    for (int k = 0; k < dcache_pkg::NumBanks; k++) begin
      bank_idx_o[k] = wr_idx_i;
    end
    if (wr_cl_vld_i) begin
      // refill writes the whole line across all banks
      bank_req_o = '1;
      bank_we_o  = '1;
      for (int k = 0; k < dcache_pkg::NumBanks; k++) begin
        bank_idx_o[k] = wr_cl_idx_i;
      end
    end else begin
      if (rd_acked_i) begin
        bank_req_o[rd_bank] = 1'b1;
        bank_idx_o[rd_bank] = rd_idx_i;
      end
      if (wr_ack_o) begin
        bank_req_o[wr_bank] = 1'b1;
        bank_we_o[wr_bank]  = 1'b1;
      end
    end
  end

  ////////////////////
  // write data steering
  ////////////////////

  for (genvar k = 0; k < dcache_pkg::NumBanks; k++) begin : gen_bank
    for (genvar w = 0; w < dcache_pkg::NumWays; w++) begin : gen_way
      logic cl_wr;
      logic word_wr;

      assign cl_wr   = wr_cl_vld_i & wr_cl_we_i[w];
      assign word_wr = wr_ack_o & wr_req_i[w] & (wr_bank == dcache_pkg::bank_sel_t'(k));

      assign bank_be_o[k][w] = cl_wr   ? wr_cl_data_be_i[k*BeWidth +: BeWidth] :
                               word_wr ? wr_data_be_i : '0;
      assign bank_wdata_o[k][w] = cl_wr ?
          wr_cl_data_i[k*dcache_pkg::WordWidth +: dcache_pkg::WordWidth] : wr_data_i;
    end
  end

  // the word write targets exactly one way
  always_comb begin : p_wr_check
    if (wr_ack_o) begin
      wr_way_onehot : assert ($onehot(wr_req_i))
        else $error("[dcache] word write request is not one-hot");
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_data_banks.sv
////////////////////
// dcache data banks
// one synchronous sram per word offset, each entry holding the
// word of every way side by side with a byte-masked write
////////////////////
`default_nettype none

module dcache_data_banks (
  input  logic                                                    clk_i,
  input  logic [dcache_pkg::NumBanks-1:0]                         bank_req_i,
  input  logic [dcache_pkg::NumBanks-1:0]                         bank_we_i,
  input  dcache_pkg::idx_t [dcache_pkg::NumBanks-1:0]             bank_idx_i,
  input  dcache_pkg::word_be_t [dcache_pkg::NumBanks-1:0][dcache_pkg::NumWays-1:0] bank_be_i,
  input  dcache_pkg::word_t [dcache_pkg::NumBanks-1:0][dcache_pkg::NumWays-1:0] bank_wdata_i,
  output dcache_pkg::word_t [dcache_pkg::NumBanks-1:0][dcache_pkg::NumWays-1:0] bank_rdata_o
);

  localparam int unsigned NumBytes = dcache_pkg::WordWidth / 8;

  for (genvar k = 0; k < dcache_pkg::NumBanks; k++) begin : gen_bank
    dcache_pkg::word_t [dcache_pkg::NumWays-1:0] mem_q [dcache_pkg::NumSets];
    dcache_pkg::word_t [dcache_pkg::NumWays-1:0] rdata_q;

    // read data is held until the next read of this bank
    always_ff @(posedge clk_i) begin : p_sram
      if (bank_req_i[k]) begin
        if (bank_we_i[k]) begin
          for (int w = 0; w < dcache_pkg::NumWays; w++) begin
            for (int b = 0; b < NumBytes; b++) begin
              if (bank_be_i[k][w][b]) begin
                mem_q[bank_idx_i[k]][w][8*b +: 8] <= bank_wdata_i[k][w][8*b +: 8];
              end
            end
          end
        end else begin
          rdata_q <= mem_q[bank_idx_i[k]];
        end
      end
    end

    assign bank_rdata_o[k] = rdata_q;
  end

endmodule

`default_nettype wire

//--- design/dcache_hit_select.sv
////////////////////
// dcache hit select
// keeps the context of the granted read for one cycle, compares
// the late tag against every way and picks the hitting word
// a refill word is forwarded straight to the read data
////////////////////
`default_nettype none

module dcache_hit_select #(
  parameter int unsigned NumPorts = 2,
  localparam int unsigned SelWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       rd_acked_i,
  input  logic [SelWidth-1:0]                        rd_sel_i,
  input  dcache_pkg::tag_t [NumPorts-1:0]            rd_tag_i,
  input  dcache_pkg::off_t                           rd_off_i,
  input  logic                                       wr_cl_vld_i,
  input  dcache_pkg::off_t                           wr_cl_off_i,
  input  dcache_pkg::line_t                          wr_cl_data_i,
  input  dcache_pkg::tag_t [dcache_pkg::NumWays-1:0] tag_rdata_i,
  input  dcache_pkg::way_mask_t                      vld_bits_i,
  input  dcache_pkg::word_t [dcache_pkg::NumBanks-1:0][dcache_pkg::NumWays-1:0] bank_rdata_i,
  output dcache_pkg::way_mask_t                      rd_hit_oh_o,
  output dcache_pkg::way_mask_t                      rd_vld_bits_o,
  output dcache_pkg::word_t                          rd_data_o
);

  logic                  cmp_en_q;
  logic [SelWidth-1:0]   sel_q;
  dcache_pkg::bank_sel_t bank_q;
  dcache_pkg::bank_sel_t cl_bank;
  dcache_pkg::tag_t      rd_tag;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cmp_en
    if (!rst_ni) begin
      cmp_en_q <= 1'b0;
    end else begin
      cmp_en_q <= rd_acked_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_ctx
    if (rd_acked_i) begin
      sel_q  <= rd_sel_i;
      bank_q <= dcache_pkg::bank_of(rd_off_i);
    end
  end

  // tag of the granted port arrives one cycle after its grant
  assign rd_tag        = rd_tag_i[sel_q];
  assign rd_vld_bits_o = vld_bits_i;
  assign cl_bank       = dcache_pkg::bank_of(wr_cl_off_i);

  for (genvar w = 0; w < dcache_pkg::NumWays; w++) begin : gen_cmp
    assign rd_hit_oh_o[w] = cmp_en_q & vld_bits_i[w] & (tag_rdata_i[w] == rd_tag);
  end

  always_comb begin : p_readout
    dcache_pkg::word_t hit_word;
    // way 0 unless a way hits, lowest hitting way first
    hit_word = bank_rdata_i[bank_q][0];
    for (int w = dcache_pkg::NumWays - 1; w >= 0; w--) begin
      if (rd_hit_oh_o[w]) begin
        hit_word = bank_rdata_i[bank_q][w];
      end
    end
    if (wr_cl_vld_i) begin
      rd_data_o = wr_cl_data_i[32'(cl_bank)*dcache_pkg::WordWidth +: dcache_pkg::WordWidth];
    end else begin
      rd_data_o = hit_word;
    end
  end

  // a tag is never allocated in two ways of one set
  hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_acked_i |=> $onehot0(rd_hit_oh_o))
    else $error("[dcache] read hit vector is not one-hot");

endmodule

`default_nettype wire

//--- design/dcache_mem.sv
////////////////////
// dcache memory core
// two-way tag and banked data arrays of the write-through l1 data
// cache with arbitrated read ports, line refill and word write
////////////////////
`default_nettype none

module dcache_mem #(
  parameter int unsigned NumPorts = 2,
  localparam int unsigned SelWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // read ports, tag comes one cycle after the acknowledge
  input  dcache_pkg::tag_t [NumPorts-1:0] rd_tag_i,
  input  dcache_pkg::idx_t [NumPorts-1:0] rd_idx_i,
  input  dcache_pkg::off_t [NumPorts-1:0] rd_off_i,
  input  logic [NumPorts-1:0]             rd_req_i,
  input  logic [NumPorts-1:0]             rd_prio_i,
  output logic [NumPorts-1:0]             rd_ack_o,
  output dcache_pkg::way_mask_t           rd_vld_bits_o,
  output dcache_pkg::way_mask_t           rd_hit_oh_o,
  output dcache_pkg::word_t               rd_data_o,
  // line refill
  input  logic                            wr_cl_vld_i,
  input  dcache_pkg::way_mask_t           wr_cl_we_i,
  input  dcache_pkg::tag_t                wr_cl_tag_i,
  input  dcache_pkg::idx_t                wr_cl_idx_i,
  input  dcache_pkg::off_t                wr_cl_off_i,
  input  dcache_pkg::line_t               wr_cl_data_i,
  input  dcache_pkg::line_be_t            wr_cl_data_be_i,
  input  dcache_pkg::way_mask_t           wr_vld_bits_i,
  // single word write, no tag access
  input  dcache_pkg::way_mask_t           wr_req_i,
  output logic                            wr_ack_o,
  input  dcache_pkg::idx_t                wr_idx_i,
  input  dcache_pkg::off_t                wr_off_i,
  input  dcache_pkg::word_t               wr_data_i,
  input  dcache_pkg::word_be_t            wr_data_be_i
);

  logic                  rd_acked;
  logic [SelWidth-1:0]   rd_sel;
  dcache_pkg::idx_t      sel_idx;
  dcache_pkg::off_t      sel_off;
  dcache_pkg::way_mask_t vld_req;
  dcache_pkg::idx_t      vld_addr;
  dcache_pkg::way_mask_t vld_bits;
  dcache_pkg::tag_t [dcache_pkg::NumWays-1:0] tag_rdata;

  logic [dcache_pkg::NumBanks-1:0] bank_req;
  logic [dcache_pkg::NumBanks-1:0] bank_we;
  dcache_pkg::idx_t [dcache_pkg::NumBanks-1:0] bank_idx;
  dcache_pkg::word_be_t [dcache_pkg::NumBanks-1:0][dcache_pkg::NumWays-1:0] bank_be;
  dcache_pkg::word_t [dcache_pkg::NumBanks-1:0][dcache_pkg::NumWays-1:0] bank_wdata;
  dcache_pkg::word_t [dcache_pkg::NumBanks-1:0][dcache_pkg::NumWays-1:0] bank_rdata;

  // fields of the granted port
  assign sel_idx  = rd_idx_i[rd_sel];
  assign sel_off  = rd_off_i[rd_sel];

  // refill owns the tag array in its cycle, a read looks up all ways
  assign vld_addr = wr_cl_vld_i ? wr_cl_idx_i : sel_idx;
  assign vld_req  = wr_cl_vld_i ? wr_cl_we_i : (rd_acked ? '1 : '0);

  dcache_read_arbiter #(
    .NumPorts(NumPorts)
  ) i_read_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_req_i   (rd_req_i),
    .rd_prio_i  (rd_prio_i),
    .wr_cl_vld_i(wr_cl_vld_i),
    .rd_ack_o   (rd_ack_o),
    .rd_acked_o (rd_acked),
    .rd_sel_o   (rd_sel)
  );

  dcache_bank_ctrl i_bank_ctrl (
    .rd_acked_i     (rd_acked),
    .rd_off_i       (sel_off),
    .rd_idx_i       (sel_idx),
    .wr_cl_vld_i    (wr_cl_vld_i),
    .wr_cl_we_i     (wr_cl_we_i),
    .wr_cl_idx_i    (wr_cl_idx_i),
    .wr_cl_data_i   (wr_cl_data_i),
    .wr_cl_data_be_i(wr_cl_data_be_i),
    .wr_req_i       (wr_req_i),
    .wr_idx_i       (wr_idx_i),
    .wr_off_i       (wr_off_i),
    .wr_data_i      (wr_data_i),
    .wr_data_be_i   (wr_data_be_i),
    .wr_ack_o       (wr_ack_o),
    .bank_req_o     (bank_req),
    .bank_we_o      (bank_we),
    .bank_idx_o     (bank_idx),
    .bank_be_o      (bank_be),
    .bank_wdata_o   (bank_wdata)
  );

  dcache_data_banks i_data_banks (
    .clk_i       (clk_i),
    .bank_req_i  (bank_req),
    .bank_we_i   (bank_we),
    .bank_idx_i  (bank_idx),
    .bank_be_i   (bank_be),
    .bank_wdata_i(bank_wdata),
    .bank_rdata_o(bank_rdata)
  );

  dcache_tag_array i_tag_array (
    .clk_i        (clk_i),
    .vld_req_i    (vld_req),
    .vld_we_i     (wr_cl_vld_i),
    .vld_addr_i   (vld_addr),
    .wr_tag_i     (wr_cl_tag_i),
    .wr_vld_bits_i(wr_vld_bits_i),
    .tag_rdata_o  (tag_rdata),
    .vld_bits_o   (vld_bits)
  );

  dcache_hit_select #(
    .NumPorts(NumPorts)
  ) i_hit_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_acked_i   (rd_acked),
    .rd_sel_i     (rd_sel),
    .rd_tag_i     (rd_tag_i),
    .rd_off_i     (sel_off),
    .wr_cl_vld_i  (wr_cl_vld_i),
    .wr_cl_off_i  (wr_cl_off_i),
    .wr_cl_data_i (wr_cl_data_i),
    .tag_rdata_i  (tag_rdata),
    .vld_bits_i   (vld_bits),
    .bank_rdata_i (bank_rdata),
    .rd_hit_oh_o  (rd_hit_oh_o),
    .rd_vld_bits_o(rd_vld_bits_o),
    .rd_data_o    (rd_data_o)
  );

endmodule

`default_nettype wire

//--- design/dcache_pkg.sv
////////////////////
// dcache core package
// geometry of the two-way write-through l1 data cache core
// and the vector types that carry those widths
////////////////////
`default_nettype none

package dcache_pkg;

  ////////////////////
  // geometry
  ////////////////////

  localparam int unsigned NumWays       = 2;
  localparam int unsigned NumBanks      = 4;
  localparam int unsigned WordWidth     = 32;
  localparam int unsigned IdxWidth      = 4;
  localparam int unsigned TagWidth      = 8;
  localparam int unsigned OffWidth      = 4;
  localparam int unsigned WordAlignBits = 2;

  // sets per way, one sram entry each
  localparam int unsigned NumSets = 2 ** IdxWidth;

  ////////////////////
  // types
  ////////////////////

  typedef logic [WordWidth-1:0]              word_t;
  typedef logic [WordWidth/8-1:0]            word_be_t;
  // word k of a line sits at bits 32k upward
  typedef logic [NumBanks*WordWidth-1:0]     line_t;
  typedef logic [NumBanks*WordWidth/8-1:0]   line_be_t;
  typedef logic [TagWidth-1:0]               tag_t;
  typedef logic [IdxWidth-1:0]               idx_t;
  typedef logic [OffWidth-1:0]               off_t;
  typedef logic [OffWidth-WordAlignBits-1:0] bank_sel_t;
  typedef logic [NumWays-1:0]                way_mask_t;

  // word index of a byte offset, which is also the bank number
  function automatic bank_sel_t bank_of(off_t off);
    return off[OffWidth-1:WordAlignBits];
  endfunction

endpackage

`default_nettype wire

//--- design/dcache_read_arbiter.sv
////////////////////
// dcache read arbiter
// masks low priority read requests while a high priority one is
// pending and grants the rest round-robin, one port per cycle
// no grant is given while a refill is writing the arrays
////////////////////
`default_nettype none

module dcache_read_arbiter #(
  parameter int unsigned NumPorts = 2,
  localparam int unsigned SelWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NumPorts-1:0] rd_req_i,
  input  logic [NumPorts-1:0] rd_prio_i,
  input  logic                wr_cl_vld_i,
  output logic [NumPorts-1:0] rd_ack_o,
  output logic                rd_acked_o,
  output logic [SelWidth-1:0] rd_sel_o
);

  logic [NumPorts-1:0] req_prio;
  logic [NumPorts-1:0] req_masked;
  logic [SelWidth-1:0] rr_q;
  logic [SelWidth-1:0] sel;
  logic                found;

  // high priority requests hide the low priority ones
  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  // first remaining request at or after the pointer wins
  always_comb begin : p_rr_search
    int unsigned idx;
    found = 1'b0;
    sel   = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      idx = (32'(rr_q) + i) % NumPorts;
      if (!found && req_masked[idx]) begin
        found = 1'b1;
        sel   = SelWidth'(idx);
      end
    end
  end

  assign rd_acked_o = found & ~wr_cl_vld_i;
  assign rd_sel_o   = sel;

  always_comb begin : p_ack
    rd_ack_o = '0;
    if (rd_acked_o) begin
      rd_ack_o[sel] = 1'b1;
    end
  end

  // pointer moves just past the port that was granted
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_acked_o) begin
      rr_q <= (sel == SelWidth'(NumPorts - 1)) ? '0 : sel + 1'b1;
    end
  end

  // a port just granted yields to any other competitor on the next grant
  rr_moves_on : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(rst_ni) && $past(rd_acked_o) && rd_acked_o &&
     ((req_masked & ~$past(rd_ack_o)) != '0))
    |-> (rd_ack_o != $past(rd_ack_o)))
    else $error("[dcache] round-robin grant did not move past the granted port");

endmodule

`default_nettype wire

//--- design/dcache_tag_array.sv
////////////////////
// dcache tag array
// per way sram of tag plus valid bit, written by the refill and
// read by every enabled way one cycle after the request
////////////////////
`default_nettype none

module dcache_tag_array (
  input  logic                                        clk_i,
  input  dcache_pkg::way_mask_t                       vld_req_i,
  input  logic                                        vld_we_i,
  input  dcache_pkg::idx_t                            vld_addr_i,
  input  dcache_pkg::tag_t                            wr_tag_i,
  input  dcache_pkg::way_mask_t                       wr_vld_bits_i,
  output dcache_pkg::tag_t [dcache_pkg::NumWays-1:0]  tag_rdata_o,
  output dcache_pkg::way_mask_t                       vld_bits_o
);

  localparam int unsigned EntryWidth = dcache_pkg::TagWidth + 1;

  for (genvar w = 0; w < dcache_pkg::NumWays; w++) begin : gen_way
    // valid bit sits above the tag
    logic [EntryWidth-1:0] mem_q [dcache_pkg::NumSets];
    logic [EntryWidth-1:0] rdata_q;

    always_ff @(posedge clk_i) begin : p_sram
      if (vld_req_i[w]) begin
        if (vld_we_i) begin
          mem_q[vld_addr_i] <= {wr_vld_bits_i[w], wr_tag_i};
        end else begin
          rdata_q <= mem_q[vld_addr_i];
        end
      end
    end

    assign tag_rdata_o[w] = rdata_q[dcache_pkg::TagWidth-1:0];
    assign vld_bits_o[w]  = rdata_q[dcache_pkg::TagWidth];
  end

endmodule

`default_nettype wire

//--- dv/dcache_mem_stimulus.txt
# name op port prio idx off tag way be woff d0 d1 d2 d3 exp_hit exp_data
# numbers in hex, prio and way hold one bit per port or way, unused fields are 0
reset_state  idle    0 0 0 0 00 0 0 0 00000000 00000000 00000000 00000000 0 00000000
fill_s3_w0   refill  0 0 3 0 33 1 0 0 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 0 a0a0a0a0
fill_s3_w1   refill  0 0 3 8 5a 2 0 0 11110000 22221111 33332222 44443333 0 33332222
fill_s7_w1   refill  0 0 7 4 77 2 0 0 7777aaaa 7777bbbb 7777cccc 7777dddd 0 7777bbbb
read_hit     read    0 0 3 4 5a 0 0 0 00000000 00000000 00000000 00000000 2 22221111
read_miss    read    1 0 3 4 5b 0 0 0 00000000 00000000 00000000 00000000 0 a1a1a1a1
refill_stall stall   0 0 7 c a1 1 0 0 55550000 66661111 77772222 88883333 1 88883333
word_write   write   0 0 3 0 00 2 5 4 deadbeef 00000000 00000000 00000000 0 00000000
read_merged  read    1 0 3 4 5a 0 0 0 00000000 00000000 00000000 00000000 2 22ad11ef
prio_port1   dual    1 2 7 c a1 0 0 0 00000000 00000000 00000000 00000000 1 88883333
rr_first_p1  dual    1 0 3 0 33 0 0 0 00000000 00000000 00000000 00000000 1 a0a0a0a0
rr_step_p1   read    1 0 3 c 5a 0 0 0 00000000 00000000 00000000 00000000 2 44443333
rr_first_p0  dual    0 0 7 4 77 0 0 0 00000000 00000000 00000000 00000000 2 7777bbbb
write_near   collide 0 0 3 4 5a 2 0 4 00000000 00000000 00000000 00000000 2 22ad11ef
write_far    beside  1 0 3 4 5a 2 0 8 00000000 00000000 00000000 00000000 2 22ad11ef

//--- dv/dcache_mem_tb.sv
////////////////////
// dcache core testbench
// plays the stimulus file against the cache memory core, one
// operation per line, and checks acknowledges, hits and read data
////////////////////
`default_nettype none

module dcache_mem_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    AckTimeout = 20;
  localparam string StimFile   = "dv/dcache_mem_stimulus.txt";

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  dcache_pkg::tag_t [1:0]         rd_tag_i;
  dcache_pkg::idx_t [1:0]         rd_idx_i;
  dcache_pkg::off_t [1:0]         rd_off_i;
  logic [1:0]                     rd_req_i;
  logic [1:0]                     rd_prio_i;
  logic [1:0]                     rd_ack_o;
  dcache_pkg::way_mask_t          rd_vld_bits_o;
  dcache_pkg::way_mask_t          rd_hit_oh_o;
  dcache_pkg::word_t              rd_data_o;
  logic                           wr_cl_vld_i;
  dcache_pkg::way_mask_t          wr_cl_we_i;
  dcache_pkg::tag_t               wr_cl_tag_i;
  dcache_pkg::idx_t               wr_cl_idx_i;
  dcache_pkg::off_t               wr_cl_off_i;
  dcache_pkg::line_t              wr_cl_data_i;
  dcache_pkg::line_be_t           wr_cl_data_be_i;
  dcache_pkg::way_mask_t          wr_vld_bits_i;
  dcache_pkg::way_mask_t          wr_req_i;
  logic                           wr_ack_o;
  dcache_pkg::idx_t               wr_idx_i;
  dcache_pkg::off_t               wr_off_i;
  dcache_pkg::word_t              wr_data_i;
  dcache_pkg::word_be_t           wr_data_be_i;

  // fields of the stimulus line being played
  string       line;
  string       name;
  string       op;
  logic [31:0] port, prio, idx, off, tag, way, be, woff;
  logic [31:0] d0, d1, d2, d3, exp_hit, exp_data;
  int          fd;
  int          scan_n;
  int          tests;
  int          failed;
  int          test_errors;

  // ways refilled so far in each set, every refill marks its ways valid
  dcache_pkg::way_mask_t vld_model [dcache_pkg::NumSets];

  dcache_mem #(
    .NumPorts(2)
  ) dcache_mem_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rd_tag_i       (rd_tag_i),
    .rd_idx_i       (rd_idx_i),
    .rd_off_i       (rd_off_i),
    .rd_req_i       (rd_req_i),
    .rd_prio_i      (rd_prio_i),
    .rd_ack_o       (rd_ack_o),
    .rd_vld_bits_o  (rd_vld_bits_o),
    .rd_hit_oh_o    (rd_hit_oh_o),
    .rd_data_o      (rd_data_o),
    .wr_cl_vld_i    (wr_cl_vld_i),
    .wr_cl_we_i     (wr_cl_we_i),
    .wr_cl_tag_i    (wr_cl_tag_i),
    .wr_cl_idx_i    (wr_cl_idx_i),
    .wr_cl_off_i    (wr_cl_off_i),
    .wr_cl_data_i   (wr_cl_data_i),
    .wr_cl_data_be_i(wr_cl_data_be_i),
    .wr_vld_bits_i  (wr_vld_bits_i),
    .wr_req_i       (wr_req_i),
    .wr_ack_o       (wr_ack_o),
    .wr_idx_i       (wr_idx_i),
    .wr_off_i       (wr_off_i),
    .wr_data_i      (wr_data_i),
    .wr_data_be_i   (wr_data_be_i)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////
  // timing and driving
  ////////////////////

  // inputs change 1 ns after the rising edge, outputs are sampled mid cycle
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_sample();
    #4;
  endtask

  function automatic logic [1:0] grant_of(input logic p);
    return p ? 2'b10 : 2'b01;
  endfunction

  task automatic clear_inputs();
    rd_tag_i        = '0;
    rd_idx_i        = '0;
    rd_off_i        = '0;
    rd_req_i        = '0;
    rd_prio_i       = '0;
    wr_cl_vld_i     = 1'b0;
    wr_cl_we_i      = '0;
    wr_cl_tag_i     = '0;
    wr_cl_idx_i     = '0;
    wr_cl_off_i     = '0;
    wr_cl_data_i    = '0;
    wr_cl_data_be_i = '0;
    wr_vld_bits_i   = '0;
    wr_req_i        = '0;
    wr_idx_i        = '0;
    wr_off_i        = '0;
    wr_data_i       = '0;
    wr_data_be_i    = '0;
  endtask

  // the tag is held from the request on, so it is there the cycle after the grant
  task automatic drive_read(input logic p);
    rd_req_i[p] = 1'b1;
    rd_idx_i[p] = idx[3:0];
    rd_off_i[p] = off[3:0];
    rd_tag_i[p] = tag[7:0];
    rd_prio_i   = prio[1:0];
  endtask

  task automatic drive_refill();
    wr_cl_vld_i     = 1'b1;
    wr_cl_we_i      = way[1:0];
    wr_cl_tag_i     = tag[7:0];
    wr_cl_idx_i     = idx[3:0];
    wr_cl_off_i     = off[3:0];
    wr_cl_data_i    = {d3, d2, d1, d0};
    wr_cl_data_be_i = '1;
    wr_vld_bits_i   = way[1:0];
    vld_model[idx[3:0]] = vld_model[idx[3:0]] | way[1:0];
  endtask

  task automatic drive_write();
    wr_req_i     = way[1:0];
    wr_idx_i     = idx[3:0];
    wr_off_i     = woff[3:0];
    wr_data_i    = d0;
    wr_data_be_i = be[3:0];
  endtask

  ////////////////////
  // checks and waits
  ////////////////////

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s %s expected %h actual %h", name, what, exp, act);
      test_errors++;
    end
  endtask

  // ways never refilled hold unknown valid bits and are left out
  task automatic check_read();
    check_value("hit", exp_hit, 32'(rd_hit_oh_o));
    check_value("data", exp_data, rd_data_o);
    check_value("valid", 32'(vld_model[idx[3:0]]),
                32'(rd_vld_bits_o & vld_model[idx[3:0]]));
  endtask

  task automatic wait_rd_ack(output logic [1:0] ack);
    int n;
    n = 0;
    while (rd_ack_o == 2'b00 && n < AckTimeout) begin
      next_cycle();
      wait_sample();
      n++;
    end
    ack = rd_ack_o;
    assert (ack != 2'b00) else begin
      $display("test %s: no read acknowledge within %0d cycles", name, AckTimeout);
      test_errors++;
    end
  endtask

  task automatic wait_wr_ack();
    int n;
    n = 0;
    while (!wr_ack_o && n < AckTimeout) begin
      next_cycle();
      wait_sample();
      n++;
    end
    assert (wr_ack_o) else begin
      $display("test %s: no write acknowledge within %0d cycles", name, AckTimeout);
      test_errors++;
    end
  endtask

  ////////////////////
  // operations
  ////////////////////

  task automatic idle_check();
    next_cycle();
    clear_inputs();
    wait_sample();
    check_value("read ack", 32'h0, 32'(rd_ack_o));
    check_value("write ack", 32'h0, 32'(wr_ack_o));
    check_value("hit", exp_hit, 32'(rd_hit_oh_o));
  endtask

  task automatic refill_line();
    next_cycle();
    clear_inputs();
    drive_refill();
    wait_sample();
    check_value("forward", exp_data, rd_data_o);
    next_cycle();
    clear_inputs();
    wait_sample();
    check_value("hit after refill", exp_hit, 32'(rd_hit_oh_o));
  endtask

  task automatic single_read();
    logic [1:0] ack;
    next_cycle();
    clear_inputs();
    drive_read(port[0]);
    wait_sample();
    wait_rd_ack(ack);
    check_value("grant", 32'(grant_of(port[0])), 32'(ack));
    next_cycle();
    rd_req_i = '0;
    wait_sample();
    check_read();
  endtask

  // a read of the line that is being refilled waits for the refill to drop
  task automatic stalled_read();
    logic [1:0] ack;
    next_cycle();
    clear_inputs();
    drive_refill();
    drive_read(port[0]);
    wait_sample();
    check_value("forward", exp_data, rd_data_o);
    check_value("read ack during refill", 32'h0, 32'(rd_ack_o));
    next_cycle();
    wr_cl_vld_i = 1'b0;
    wait_sample();
    wait_rd_ack(ack);
    check_value("grant", 32'(grant_of(port[0])), 32'(ack));
    next_cycle();
    rd_req_i = '0;
    wait_sample();
    check_read();
  endtask

  // both ports read the same word, port column names the first grant
  task automatic dual_read();
    logic [1:0] ack;
    next_cycle();
    clear_inputs();
    drive_read(1'b0);
    drive_read(1'b1);
    wait_sample();
    wait_rd_ack(ack);
    check_value("first grant", 32'(grant_of(port[0])), 32'(ack));
    next_cycle();
    rd_req_i[port[0]] = 1'b0;
    wait_sample();
    check_read();
    wait_rd_ack(ack);
    check_value("second grant", 32'(grant_of(!port[0])), 32'(ack));
    next_cycle();
    rd_req_i = '0;
    wait_sample();
    check_read();
  endtask

  task automatic word_write();
    next_cycle();
    clear_inputs();
    drive_write();
    wait_sample();
    wait_wr_ack();
  endtask

  // same_cycle says whether the write is expected beside the read grant
  task automatic read_with_write(input logic same_cycle);
    logic [1:0] ack;
    next_cycle();
    clear_inputs();
    drive_read(port[0]);
    drive_write();
    wait_sample();
    wait_rd_ack(ack);
    check_value("grant", 32'(grant_of(port[0])), 32'(ack));
    check_value("write ack beside read", 32'(same_cycle), 32'(wr_ack_o));
    next_cycle();
    rd_req_i = '0;
    if (same_cycle) begin
      wr_req_i = '0;
    end
    wait_sample();
    check_read();
    if (!same_cycle) begin
      wait_wr_ack();
    end
  endtask

  task automatic play_line();
    test_errors = 0;
    if (op == "idle") begin
      idle_check();
    end else if (op == "refill") begin
      refill_line();
    end else if (op == "read") begin
      single_read();
    end else if (op == "stall") begin
      stalled_read();
    end else if (op == "dual") begin
      dual_read();
    end else if (op == "write") begin
      word_write();
    end else if (op == "collide") begin
      read_with_write(1'b0);
    end else if (op == "beside") begin
      read_with_write(1'b1);
    end else begin
      $display("test %s: unknown operation %s", name, op);
      test_errors++;
    end
    tests++;
    if (test_errors != 0) begin
      failed++;
    end
    $display("test %s: %s", name, (test_errors == 0) ? "ok" : "errors found");
  endtask

  initial begin : p_main
    for (int s = 0; s < dcache_pkg::NumSets; s++) begin
      vld_model[s] = '0;
    end
    rst_ni = 1'b0;
    clear_inputs();
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", StimFile);
      failed++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          scan_n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           name, op, port, prio, idx, off, tag, way, be, woff,
                           d0, d1, d2, d3, exp_hit, exp_data);
          if (scan_n == 16) begin
            play_line();
          end else if (scan_n > 0) begin
            $display("stimulus line not understood: %s", line);
            failed++;
          end
        end
      end
      $fclose(fd);
    end
    $display("%0d tests run, %0d failed", tests, failed);
    if (failed == 0 && tests > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the dcache core testbench with verilator and runs it
# the run counts as passed only when the pass line shows up

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module dcache_mem_tb; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vdcache_mem_tb)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "STATUS: PASS" <<< "$out"; then
  exit 0
fi
echo "pass line not found in the simulation output"
exit 1

//--- tb.f
design/dcache_pkg.sv
design/dcache_read_arbiter.sv
design/dcache_bank_ctrl.sv
design/dcache_data_banks.sv
design/dcache_tag_array.sv
design/dcache_hit_select.sv
design/dcache_mem.sv
dv/dcache_mem_tb.sv
